//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

    // ====================
    // Memory geometry
    // ====================

    // Width of a byte address on the memory ports
    localparam int ADDR_WIDTH = 16;

    // Bytes held in one memory word
    localparam int WORD_BYTES = 8;

    // Width of a memory word in bits
    localparam int WORD_WIDTH = WORD_BYTES * 8;

    // Low address bits that pick a byte inside a word
    localparam int WORD_SHIFT = 3;

    // A byte address in memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One memory word, byte 0 sits in the lowest eight bits
    typedef logic [WORD_WIDTH-1:0] word_t;

endpackage

//--- src/token_pkg.sv
package token_pkg;

    // ====================
    // Token format
    // ====================

    // Longest token that fits in one output word
    localparam int TOKEN_BYTES = 8;

    // A packed token, the last character parsed sits in the low byte
    typedef logic [TOKEN_BYTES*8-1:0] token_t;

    // One ASCII character
    typedef logic [7:0] char_t;

    // Characters that steer the parser
    localparam char_t CHAR_SPACE  = 8'h20;
    localparam char_t CHAR_COMMA  = 8'h2c;
    localparam char_t CHAR_DQUOTE = 8'h22;
    localparam char_t CHAR_SQUOTE = 8'h27;
    localparam char_t CHAR_NUL    = 8'h00;

    // ====================
    // Control encodings
    // ====================

    // Commands from the parser to the character stream
    typedef enum logic [1:0] {
        STREAM_NONE,
        STREAM_START,
        STREAM_NEXT
    } stream_cmd_t;

    // Parser FSM states
    typedef enum logic [2:0] {
        PS_IDLE,
        PS_START_TOKEN,
        PS_PARSE,
        PS_END_TOKEN,
        PS_SKIP_SPACES,
        PS_SKIP_COMMA,
        PS_TERMINATE
    } parse_state_t;

endpackage

//--- src/amci_if.sv
`timescale 1ns/10ps

interface amci_if;
    import mem_bus_pkg::*;

    // Read side, the client strobes read while ridle is high
    addr_t raddr;
    logic  read;
    word_t rdata;
    logic  ridle;

    // Write side, the client strobes write while widle is high
    addr_t waddr;
    word_t wdata;
    logic  write;
    logic  widle;

    // The character stream only reads
    modport reader (output raddr, output read, input rdata, input ridle);

    // The parser only writes
    modport writer (output waddr, output wdata, output write, input widle);

    // The memory master serves both sides
    modport bus (
        input  raddr, input read, output rdata, output ridle,
        input  waddr, input wdata, input write, output widle
    );

endinterface

//--- src/char_stream_if.sv
`timescale 1ns/10ps

interface char_stream_if;
    import mem_bus_pkg::*;
    import token_pkg::*;

    // One-cycle command from the parser, STREAM_NONE otherwise
    stream_cmd_t cmd;

    // Byte address of the string, only looked at with STREAM_START
    addr_t addr;

    // Current character and its valid level
    char_t data;
    logic  valid;

    modport parser (output cmd, output addr, input data, input valid);
    modport stream (input cmd, input addr, output data, output valid);

endinterface

//--- src/mem_master.sv
`timescale 1ns/10ps

module mem_master (
    input  logic               clk,
    input  logic               resetn,

    // Control port shared by the stream and the parser
    amci_if.bus                amci,

    // Memory read port
    output logic               mem_rd,
    output mem_bus_pkg::addr_t mem_raddr,
    input  logic               mem_rvalid,
    input  mem_bus_pkg::word_t mem_rdata,

    // Memory write port
    output logic               mem_wr,
    output mem_bus_pkg::addr_t mem_waddr,
    output mem_bus_pkg::word_t mem_wdata,
    input  logic               mem_wdone
);
    import mem_bus_pkg::*;

    // Set from the request strobe until the memory answers
    logic rd_busy;
    logic wr_busy;

    // The idle flags are just the inverted busy flags
    assign amci.ridle = !rd_busy;
    assign amci.widle = !wr_busy;

    // ====================
    // Request strobes and busy flags
    // ====================
    always_ff @(posedge clk) begin
        // Memory strobes last one cycle
        mem_rd <= 1'b0;
        mem_wr <= 1'b0;

        if (!resetn) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            // A read request goes out one cycle after the client strobe
            if (amci.read) begin
                mem_rd  <= 1'b1;
                rd_busy <= 1'b1;
            end else if (mem_rvalid) begin
                rd_busy <= 1'b0;
            end

            // Same for a write, which ends on the done pulse
            if (amci.write) begin
                mem_wr  <= 1'b1;
                wr_busy <= 1'b1;
            end else if (mem_wdone) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // ====================
    // Address and data registers
    // ====================
    always_ff @(posedge clk) begin
        if (amci.read) begin
            mem_raddr <= amci.raddr;
        end
        if (amci.write) begin
            mem_waddr <= amci.waddr;
            mem_wdata <= amci.wdata;
        end

        // The read word is held until the next read returns
        if (mem_rvalid) begin
            amci.rdata <= mem_rdata;
        end
    end

endmodule

//--- src/char_istream.sv
`timescale 1ns/10ps

module char_istream (
    input  logic      clk,
    input  logic      resetn,
    char_stream_if.stream stream,
    amci_if.reader    amci
);
    import mem_bus_pkg::*;
    import token_pkg::*;

    // Stream FSM, READY means a character is on data
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WAIT,
        ST_SELECT,
        ST_READY
    } stream_state_t;

    stream_state_t state;

    // Byte address of the character being presented
    addr_t byte_addr;

    // Offset of that character inside the held word
    logic [WORD_SHIFT-1:0] byte_off;

    assign byte_off = byte_addr[WORD_SHIFT-1:0];

    // Reads always ask for the whole word that holds the byte
    assign amci.raddr = byte_addr & ~addr_t'(WORD_BYTES - 1);

    // The read strobe goes out in the same cycle the master reports idle
    assign amci.read = (state == ST_FETCH) && amci.ridle;

    // ====================
    // Stream FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= ST_IDLE;
            stream.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_READY: begin
                    if (stream.cmd == STREAM_START) begin
                        // New string, always fetch its first word
                        byte_addr    <= stream.addr;
                        stream.valid <= 1'b0;
                        state        <= ST_FETCH;
                    end else if (stream.cmd == STREAM_NEXT) begin
                        byte_addr    <= byte_addr + addr_t'(1);
                        stream.valid <= 1'b0;
                        // Leaving the last byte of a word means a new read
                        if (&byte_off) begin
                            state <= ST_FETCH;
                        end else begin
                            state <= ST_SELECT;
                        end
                    end
                end

                // Wait here until the master can take the request
                ST_FETCH: begin
                    if (amci.ridle) begin
                        state <= ST_WAIT;
                    end
                end

                // ridle is low from the cycle after the strobe until the data lands
                ST_WAIT: begin
                    if (amci.ridle) begin
                        stream.data  <= amci.rdata[byte_off*8 +: 8];
                        stream.valid <= 1'b1;
                        state        <= ST_READY;
                    end
                end

                // Next byte of the word already held by the master
                ST_SELECT: begin
                    stream.data  <= amci.rdata[byte_off*8 +: 8];
                    stream.valid <= 1'b1;
                    state        <= ST_READY;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/token_parser.sv
`timescale 1ns/10ps

module token_parser (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  mem_bus_pkg::addr_t  str_addr,
    input  mem_bus_pkg::addr_t  out_addr,
    output logic                idle,
    output token_pkg::token_t   first_token,
    char_stream_if.parser       stream,
    amci_if.writer              amci
);
    import mem_bus_pkg::*;
    import token_pkg::*;

    parse_state_t state;

    // Opening quote of the current token or nul when the token is not quoted
    char_t  quote_char;
    token_t token;

    // Where the next output word goes
    addr_t out_ptr;

    // Set once the first token of a run has been stored
    logic first_seen;

    // Character classes of the current stream character
    logic is_space;
    logic is_comma;
    logic is_nul;
    logic is_quote;
    logic quoted;
    logic at_close;
    logic plain_end;

    assign is_space  = (stream.data == CHAR_SPACE);
    assign is_comma  = (stream.data == CHAR_COMMA);
    assign is_nul    = (stream.data == CHAR_NUL);
    assign is_quote  = (stream.data == CHAR_DQUOTE) || (stream.data == CHAR_SQUOTE);
    assign quoted    = (quote_char != CHAR_NUL);
    assign at_close  = quoted && (stream.data == quote_char);
    assign plain_end = is_space || is_comma || is_nul;

    // Start address only matters together with STREAM_START
    assign stream.addr = str_addr;

    // Output words go to the running pointer and a zero word ends the list
    assign amci.waddr = out_ptr;
    assign amci.wdata = (state == PS_TERMINATE) ? word_t'(0) : token;
    assign amci.write = ((state == PS_END_TOKEN) || (state == PS_TERMINATE)) && amci.widle;

    // The run is only over once the zero word has been accepted
    assign idle = (state == PS_IDLE) && !start && amci.widle;

    // ====================
    // Stream commands
    // ====================
    always_comb begin
        stream.cmd = STREAM_NONE;
        case (state)
            PS_IDLE: begin
                if (start) begin
                    stream.cmd = STREAM_START;
                end
            end
            // Drop leading spaces and an opening quote
            PS_START_TOKEN: begin
                if (stream.valid && (is_space || is_quote)) begin
                    stream.cmd = STREAM_NEXT;
                end
            end
            // A quoted token eats everything up to its closing quote but stops at nul
            PS_PARSE: begin
                if (stream.valid && (quoted ? !is_nul : !plain_end)) begin
                    stream.cmd = STREAM_NEXT;
                end
            end
            PS_SKIP_SPACES: begin
                if (stream.valid && is_space) begin
                    stream.cmd = STREAM_NEXT;
                end
            end
            PS_SKIP_COMMA: begin
                if (stream.valid && is_comma) begin
                    stream.cmd = STREAM_NEXT;
                end
            end
            default: begin
                stream.cmd = STREAM_NONE;
            end
        endcase
    end

    // ====================
    // Parser FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= PS_IDLE;
            first_token <= '0;
            first_seen  <= 1'b0;
        end else begin
            case (state)
                PS_IDLE: begin
                    if (start) begin
                        out_ptr     <= out_addr;
                        first_token <= '0;
                        first_seen  <= 1'b0;
                        state       <= PS_START_TOKEN;
                    end
                end

                PS_START_TOKEN: begin
                    if (stream.valid && is_nul) begin
                        state <= PS_TERMINATE;
                    end else if (stream.valid && !is_space) begin
                        // The first real character also tells the quote style if any
                        quote_char <= is_quote ? stream.data : CHAR_NUL;
                        token      <= '0;
                        state      <= PS_PARSE;
                    end
                end

                PS_PARSE: begin
                    if (stream.valid) begin
                        if (quoted ? (is_nul || at_close) : plain_end) begin
                            state <= PS_END_TOKEN;
                        end else begin
                            // Older characters move up so that long tokens lose their head
                            token <= {token[$bits(token_t)-9:0], stream.data};
                        end
                    end
                end

                PS_END_TOKEN: begin
                    if (amci.widle) begin
                        if (!first_seen) begin
                            first_token <= token;
                            first_seen  <= 1'b1;
                        end
                        out_ptr <= out_ptr + addr_t'(TOKEN_BYTES);
                        state   <= PS_SKIP_SPACES;
                    end
                end

                PS_SKIP_SPACES: begin
                    if (stream.valid && !is_space) begin
                        state <= PS_SKIP_COMMA;
                    end
                end

                // At most one comma is dropped here before the next token begins
                PS_SKIP_COMMA: begin
                    if (stream.valid) begin
                        state <= PS_START_TOKEN;
                    end
                end

                PS_TERMINATE: begin
                    if (amci.widle) begin
                        state <= PS_IDLE;
                    end
                end

                default: begin
                    state <= PS_IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/tokenizer.sv
`timescale 1ns/10ps

module tokenizer (
    input  logic               clk,
    input  logic               resetn,

    // Run control
    input  logic               start,
    input  mem_bus_pkg::addr_t str_addr,
    input  mem_bus_pkg::addr_t out_addr,
    output logic               idle,
    output token_pkg::token_t  first_token,

    // Memory read port
    output logic               mem_rd,
    output mem_bus_pkg::addr_t mem_raddr,
    input  logic               mem_rvalid,
    input  mem_bus_pkg::word_t mem_rdata,

    // Memory write port
    output logic               mem_wr,
    output mem_bus_pkg::addr_t mem_waddr,
    output mem_bus_pkg::word_t mem_wdata,
    input  logic               mem_wdone
);

    // ====================
    // Internal links
    // ====================

    // Control port between the engines and the memory master
    amci_if amci ();

    // Character stream between the parser and the string reader
    char_stream_if chars ();

    // FSM that splits the string and writes out the tokens
    token_parser u_parser (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .str_addr    (str_addr),
        .out_addr    (out_addr),
        .idle        (idle),
        .first_token (first_token),
        .stream      (chars.parser),
        .amci        (amci.writer)
    );

    // Reads string words and hands out one character at a time
    char_istream u_istream (
        .clk    (clk),
        .resetn (resetn),
        .stream (chars.stream),
        .amci   (amci.reader)
    );

    // Drives the memory ports from the control port
    mem_master u_master (
        .clk        (clk),
        .resetn     (resetn),
        .amci       (amci.bus),
        .mem_rd     (mem_rd),
        .mem_raddr  (mem_raddr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_wr     (mem_wr),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wdone  (mem_wdone)
    );

endmodule

//--- tb/tokenizer_props.sv
`timescale 1ns/10ps

module tokenizer_props (
    input logic               clk,
    input logic               resetn,
    input logic               mem_rd,
    input logic               mem_rvalid,
    input logic               mem_wr,
    input mem_bus_pkg::addr_t mem_waddr,
    input logic               mem_wdone
);
    import mem_bus_pkg::*;

    // Requests that went out and still wait for their memory response
    logic rd_pending;
    logic wr_pending;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_pending <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            if (mem_rd) begin
                rd_pending <= 1'b1;
            end else if (mem_rvalid) begin
                rd_pending <= 1'b0;
            end
            if (mem_wr) begin
                wr_pending <= 1'b1;
            end else if (mem_wdone) begin
                wr_pending <= 1'b0;
            end
        end
    end

    // ====================
    // Memory port rules
    // ====================

    // One read in flight at most
    read_single: assert property (@(posedge clk) disable iff (!resetn)
        mem_rd |-> !rd_pending)
        else $error("mem_rd issued before the previous mem_rvalid");

    // One write in flight at most
    write_single: assert property (@(posedge clk) disable iff (!resetn)
        mem_wr |-> !wr_pending)
        else $error("mem_wr issued before the previous mem_wdone");

    // Output words always land on a word boundary
    write_aligned: assert property (@(posedge clk) disable iff (!resetn)
        mem_wr |-> (mem_waddr[WORD_SHIFT-1:0] == '0))
        else $error("mem_waddr not word aligned during mem_wr");

    // Nothing leaves the design in the first cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(resetn) |=> (!mem_rd && !mem_wr))
        else $error("memory strobe active right after reset");

endmodule

bind tokenizer tokenizer_props u_props (
    .clk        (clk),
    .resetn     (resetn),
    .mem_rd     (mem_rd),
    .mem_rvalid (mem_rvalid),
    .mem_wr     (mem_wr),
    .mem_waddr  (mem_waddr),
    .mem_wdone  (mem_wdone)
);

//--- tb/tokenizer_tb.sv
`timescale 1ns/10ps

module tokenizer_tb;
    import mem_bus_pkg::*;
    import token_pkg::*;

    // DUT ports
    logic   clk = 1'b0;
    logic   resetn;
    logic   start;
    addr_t  str_addr;
    addr_t  out_addr;
    logic   idle;
    token_t first_token;
    logic   mem_rd;
    addr_t  mem_raddr;
    logic   mem_rvalid = 1'b0;
    word_t  mem_rdata = '0;
    logic   mem_wr;
    addr_t  mem_waddr;
    word_t  mem_wdata;
    logic   mem_wdone = 1'b0;

    // String memory, only ever read by the model
    word_t mem [0:(1 << (ADDR_WIDTH - WORD_SHIFT)) - 1];

    // Words the DUT wrote, keyed by byte address
    word_t written [addr_t];
    addr_t last_waddr = '0;

    // Cycles left before the pending memory response
    int    rd_wait = 0;
    int    wr_wait = 0;
    addr_t rd_addr = '0;

    // Whole test file, one value per entry
    word_t test_data [0:255];

    int   watchdog_cycles;
    logic watchdog_armed = 1'b0;

    tokenizer u_tokenizer (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .str_addr    (str_addr),
        .out_addr    (out_addr),
        .idle        (idle),
        .first_token (first_token),
        .mem_rd      (mem_rd),
        .mem_raddr   (mem_raddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_wr      (mem_wr),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_wdone   (mem_wdone)
    );

    always #50 clk = ~clk;

    // ====================
    // Memory model
    // ====================
    // Requests are seen on the falling edge, answers come 1 to 4 cycles later
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        mem_wdone  = 1'b0;
        if (rd_wait > 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                mem_rdata  = mem[rd_addr[ADDR_WIDTH-1:WORD_SHIFT]];
                mem_rvalid = 1'b1;
            end
        end
        if (wr_wait > 0) begin
            wr_wait = wr_wait - 1;
            if (wr_wait == 0) begin
                mem_wdone = 1'b1;
            end
        end
        if (mem_rd) begin
            rd_addr = mem_raddr;
            rd_wait = 1 + int'($urandom % 4);
        end
        if (mem_wr) begin
            written[mem_waddr] = mem_wdata;
            last_waddr = mem_waddr;
            wr_wait = 1 + int'($urandom % 4);
        end
    end

    // ====================
    // Checks
    // ====================
    task automatic abort_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_token(input token_t actual, input token_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run("token mismatch");
        end
    endtask

    task automatic compare_addr(input addr_t actual, input addr_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run("address mismatch");
        end
    endtask

    // Fetches an output word and fails if the DUT never wrote it
    task automatic check_output(input addr_t a, input token_t expected, input string what);
        if (!written.exists(a)) begin
            $display("No output word was written at address %h for %s", a, what);
            abort_run("missing output word");
        end
        compare_token(written[a], expected, what);
    endtask

    // Budget of 200 cycles per string byte over the whole test file
    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        int     num_tests;
        int     ptr;
        int     nbytes;
        int     ntok;
        int     total_bytes;
        addr_t  s_addr;
        addr_t  o_addr;
        addr_t  a;
        token_t first_exp;

        void'($urandom(32'h3d8f7613));
        resetn   = 1'b0;
        start    = 1'b0;
        str_addr = '0;
        out_addr = '0;

        // The pattern changes with every word address
        for (int i = 0; i < (1 << (ADDR_WIDTH - WORD_SHIFT)); i++) begin
            mem[i] = {4{i[15:0]}} ^ 64'h5a5a_5a5a_5a5a_5a5a;
        end

        $readmemh("tb/tokenizer_tests.txt", test_data);
        num_tests = int'(test_data[0][15:0]);
        if (num_tests == 0) begin
            abort_run("the test file could not be read or holds no tests");
        end

        // First pass only sizes the run for the watchdog
        ptr = 1;
        total_bytes = 0;
        for (int t = 0; t < num_tests; t++) begin
            nbytes = int'(test_data[ptr + 2][15:0]);
            ntok = int'(test_data[ptr + 3 + nbytes][15:0]);
            total_bytes = total_bytes + nbytes;
            ptr = ptr + 4 + nbytes + ntok;
        end
        watchdog_cycles = total_bytes * 200;
        watchdog_armed = 1'b1;

        repeat (3) @(negedge clk);
        resetn = 1'b1;

        ptr = 1;
        for (int t = 0; t < num_tests; t++) begin
            s_addr = test_data[ptr][ADDR_WIDTH-1:0];
            o_addr = test_data[ptr + 1][ADDR_WIDTH-1:0];
            nbytes = int'(test_data[ptr + 2][15:0]);
            ptr = ptr + 3;

            // Place the string byte by byte, byte 0 is the low byte of a word
            for (int i = 0; i < nbytes; i++) begin
                a = s_addr + addr_t'(i);
                mem[a[ADDR_WIDTH-1:WORD_SHIFT]][a[WORD_SHIFT-1:0]*8 +: 8] = test_data[ptr][7:0];
                ptr = ptr + 1;
            end
            ntok = int'(test_data[ptr][15:0]);
            ptr = ptr + 1;

            // Runs follow each other without a reset in between
            @(negedge clk);
            while (!idle) @(negedge clk);
            str_addr = s_addr;
            out_addr = o_addr;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            while (!idle) @(negedge clk);

            // Token k sits at out_addr plus eight times k
            first_exp = '0;
            for (int k = 0; k < ntok; k++) begin
                a = o_addr + addr_t'(8 * k);
                check_output(a, test_data[ptr], $sformatf("test %0d token %0d", t, k));
                if (k == 0) begin
                    first_exp = test_data[ptr];
                end
                ptr = ptr + 1;
            end

            // The zero word closes the list and is the last write
            a = o_addr + addr_t'(8 * ntok);
            check_output(a, '0, $sformatf("test %0d terminator", t));
            compare_addr(last_waddr, a, $sformatf("test %0d last write address", t));
            if (ntok > 0) begin
                compare_token(first_token, first_exp, $sformatf("test %0d first_token", t));
            end
            $display("Test %0d done, %0d tokens checked", t, ntok);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- tokenizer.f
src/mem_bus_pkg.sv
src/token_pkg.sv
src/amci_if.sv
src/char_stream_if.sv
src/mem_master.sv
src/char_istream.sv
src/token_parser.sv
src/tokenizer.sv
tb/tokenizer_props.sv
tb/tokenizer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the tokenizer testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tokenizer_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f tokenizer.f \
    --top-module tokenizer_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- tb/tokenizer_tests.txt
// Per test: string address, output address, byte count, string bytes ending in nul,
// token count, tokens as 64-bit words with the first character in the highest used byte
6
// Plain words with a leading space and repeated spaces
0100 0400 a
20 61 62 20 20 63 64 20 65 00
3 6162 6364 65
// Commas with and without spaces around them
0140 0480 a
61 2c 62 20 2c 20 63 2c 64 00
4 61 62 63 64
// Double and single quoted tokens holding spaces and commas
0180 0500 e
22 78 20 79 22 2c 27 70 2c 71 27 20 7a 00
3 782079 702c71 7a
// Ten characters keep the last eight
01c0 0580 e
61 62 63 64 65 66 67 68 69 6a 20 6b 6c 00
2 636465666768696a 6b6c
// Unaligned string across two word boundaries
0205 0600 e
6f 6e 65 20 74 77 6f 20 74 68 72 65 65 00
3 6f6e65 74776f 7468726565
// Empty string writes only the zero word
030b 0680 1
00
0
